//--- cfg_pkg.sv
package cfg_pkg;

    // --------------------
    // Register file sizes and magic values
    localparam int RW_BITS = 160;
    localparam int RO_BITS = 192;

    localparam logic [15:0] RW_MAGIC = 16'h6745;
    localparam logic [15:0] RO_MAGIC = 16'h2301;

    // --------------------
    // Read-write bit positions
    localparam int RWPOS_CFG_RD_EN        = 16;   // Start a config read
    localparam int RWPOS_CFG_WR_EN        = 17;   // Start a config write
    localparam int RWPOS_WAIT_COMPLETE    = 18;   // Stall commands while busy
    localparam int RWPOS_STATUS_CL_EN     = 19;   // Timer clears status bits
    localparam int RWPOS_COMMAND_EN       = 20;   // Timer sets command bits
    localparam int RWPOS_MGMT_DI          = 64;
    localparam int RWPOS_MGMT_DWADDR      = 96;
    localparam int RWPOS_MGMT_WR_READONLY = 106;
    localparam int RWPOS_MGMT_RW1C_AS_RW  = 107;
    localparam int RWPOS_MGMT_BYTE_EN     = 108;
    localparam int RWPOS_CL_PERIOD        = 128;

    localparam logic [31:0] CL_PERIOD_DEFAULT = 32'd62500;   // 1 ms at 62.5 MHz
    localparam logic [9:0]  AUTO_WR_DWADDR    = 10'd1;       // Command/status dword
    localparam logic [31:0] AUTO_WR_DATA      = 32'hff000406;

    // Read-write reset image, high field first
    localparam logic [RW_BITS-1:0] RW_RESET = {
        CL_PERIOD_DEFAULT,      // +010 timer period
        16'h0000,               // +00E reserved
        4'hf,                   // +00D byte enables
        2'b00,                  // rw1c-as-rw and read-only-write flags
        10'd0,                  // +00C dword address
        32'd0,                  // +008 write data
        32'(RW_BITS / 8),       // +004 byte count
        16'h0000,               // +002 control bits
        RW_MAGIC                // +000
    };

    // --------------------
    // Host command and response words
    typedef struct packed {
        logic [15:0] value;     // Byte-swapped
        logic [15:0] mask;      // Byte-swapped
        logic [15:0] addr;      // Byte address, top bit selects read-write half
        logic [3:0]  typ;       // Bit 0 read, bit 1 write
        logic [11:0] rsvd;
    } cfg_cmd_t;

    typedef struct packed {
        logic [15:0] addr;
        logic [15:0] data;      // Byte-swapped
    } cfg_rsp_t;

    // --------------------
    // PCIe core side
    typedef struct packed {
        logic        rd_en;
        logic        wr_en;
        logic [31:0] di;
        logic [9:0]  dwaddr;
        logic [3:0]  byte_en;
        logic        wr_readonly;
        logic        wr_rw1c_as_rw;
    } cfg_mgmt_req_t;

    typedef struct packed {
        logic        rd_wr_done;
        logic [31:0] data_out;
    } cfg_mgmt_rsp_t;

    typedef struct packed {
        logic [7:0]  bus;
        logic [4:0]  device;
        logic [2:0]  func;
        logic [15:0] command;
        logic [15:0] status;
    } cfg_status_t;

    typedef struct packed {
        logic [31:0] di;
        logic [9:0]  dwaddr;
        logic        wr_readonly;
        logic        wr_rw1c_as_rw;
        logic [3:0]  byte_en;
    } cfg_mgmt_fields_t;

endpackage

//--- cfg_fifo.sv
`timescale 1ns/10ps

module cfg_fifo #(
    parameter type payload_t = logic [31:0],
    parameter int  DEPTH     = 16
) (
    input  logic     clk_pcie,
    input  logic     rst,
    input  logic     i_push,
    input  payload_t i_data,
    output logic     o_full,
    output logic     o_free_lt2,
    input  logic     i_pop,
    output payload_t o_data,
    output logic     o_valid
);

    localparam int PW = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CW = $clog2(DEPTH + 1);

    payload_t        mem [DEPTH];
    logic [PW-1:0]   wr_ptr;
    logic [PW-1:0]   rd_ptr;
    logic [CW-1:0]   count;
    logic            push_ok;
    logic            pop_ok;

    assign push_ok    = i_push & ~o_full;      // Drop on overflow
    assign pop_ok     = i_pop & o_valid;
    assign o_full     = (count == CW'(DEPTH));
    assign o_free_lt2 = (count > CW'(DEPTH - 2));
    assign o_valid    = (count != '0);
    assign o_data     = mem[rd_ptr];

    always_ff @(posedge clk_pcie)
    begin
        if (push_ok)
        begin
            mem[wr_ptr] <= i_data;
        end
    end

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (push_ok)
            begin
                wr_ptr <= (wr_ptr == PW'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop_ok)
            begin
                rd_ptr <= (rd_ptr == PW'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push_ok && !pop_ok)
            begin
                count <= count + 1'b1;
            end
            else if (pop_ok && !push_ok)
            begin
                count <= count - 1'b1;
            end
        end
    end

endmodule

//--- cfg_cmd_decoder.sv
`timescale 1ns/10ps

module cfg_cmd_decoder import cfg_pkg::*; (
    input  logic        clk_pcie,
    input  logic        rst,
    input  logic        i_cmd_valid,
    input  cfg_cmd_t    i_cmd,
    output logic        o_cmd_pop,
    input  logic        i_rsp_hold,
    input  logic        i_seq_busy,
    input  logic        i_wait_complete,
    output logic [15:0] o_rd_addr,
    input  logic [15:0] i_rd_data,
    output logic        o_wr_en,
    output logic [15:0] o_wr_addr,
    output logic [15:0] o_wr_value,
    output logic [15:0] o_wr_mask,
    output logic        o_access,
    output logic        o_rsp_push,
    output cfg_rsp_t    o_rsp
);

    logic cmd_rd;
    logic cmd_wr;

    // --------------------
    // Pop decision
    // A pending write must land before the next command reads or stalls on it
    assign o_cmd_pop = i_cmd_valid & ~i_rsp_hold & ~o_wr_en
                     & ~(i_wait_complete & i_seq_busy);

    assign cmd_rd    = o_cmd_pop & i_cmd.typ[0];
    assign cmd_wr    = o_cmd_pop & i_cmd.typ[1] & i_cmd.addr[15];   // Read-only half ignored

    assign o_rd_addr = i_cmd.addr;
    assign o_access  = o_cmd_pop | o_wr_en;    // Holds off the clear timer

    // --------------------
    // Control strobes
    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            o_rsp_push <= 1'b0;
            o_wr_en    <= 1'b0;
        end
        else
        begin
            o_rsp_push <= cmd_rd;
            o_wr_en    <= cmd_wr;
        end
    end

    // Payload capture
    always_ff @(posedge clk_pcie)
    begin
        if (cmd_rd)
        begin
            o_rsp.addr <= i_cmd.addr;
            o_rsp.data <= {i_rd_data[7:0], i_rd_data[15:8]};       // Host byte order
        end
        if (cmd_wr)
        begin
            o_wr_addr  <= i_cmd.addr;
            o_wr_value <= {i_cmd.value[7:0], i_cmd.value[15:8]};
            o_wr_mask  <= {i_cmd.mask[7:0], i_cmd.mask[15:8]};
        end
    end

endmodule

//--- cfg_regfile.sv
`timescale 1ns/10ps

module cfg_regfile import cfg_pkg::*; (
    input  logic             clk_pcie,
    input  logic             rst,
    input  logic [15:0]      i_rd_addr,
    output logic [15:0]      o_rd_data,
    input  logic             i_wr_en,
    input  logic [15:0]      i_wr_addr,
    input  logic [15:0]      i_wr_value,
    input  logic [15:0]      i_wr_mask,
    input  logic             i_launch,
    input  logic             i_auto_wr,
    input  logic [1:0]       i_mgmt_en,
    input  logic [31:0]      i_result,
    input  logic [9:0]       i_result_addr,
    input  logic [3:0]       i_result_be,
    input  logic             i_result_valid,
    input  cfg_status_t      i_status,
    output cfg_mgmt_fields_t o_fields,
    output logic             o_rd_start,
    output logic             o_wr_start,
    output logic             o_wait_complete,
    output logic             o_status_cl_en,
    output logic             o_command_en,
    output logic [31:0]      o_cl_period,
    output logic [15:0]      o_pcie_id
);

    logic [RW_BITS-1:0] rw_q;
    logic [RW_BITS-1:0] rw_shift;
    logic [RW_BITS-1:0] wr_mask_vec;
    logic [RW_BITS-1:0] wr_val_vec;
    logic [RO_BITS-1:0] ro;
    logic [RO_BITS-1:0] ro_shift;
    logic [17:0]        rd_bit;
    logic [17:0]        wr_bit;

    // --------------------
    // Read-only layout
    assign ro = {
        i_result,                       // +014 latched read data
        16'h0000,                       // +012
        i_result_be,
        i_result_valid,
        1'b0,
        i_result_addr,                  // +010
        16'h0000,                       // +00E
        i_status.status,                // +00C
        i_status.command,               // +00A
        i_status.func,
        i_status.device,
        i_status.bus,                   // +008 PCIe ID
        32'(RO_BITS / 8),               // +004
        14'h0000,
        i_mgmt_en,                      // +002 enables toward the core
        RO_MAGIC                        // +000
    };

    // Byte address to bit address, zero past the end
    assign rd_bit    = {i_rd_addr[14:0], 3'b000};
    assign rw_shift  = rw_q >> rd_bit;
    assign ro_shift  = ro >> rd_bit;
    assign o_rd_data = i_rd_addr[15] ? rw_shift[15:0] : ro_shift[15:0];

    assign wr_bit      = {i_wr_addr[14:0], 3'b000};
    assign wr_mask_vec = {{(RW_BITS - 16){1'b0}}, i_wr_mask} << wr_bit;
    assign wr_val_vec  = {{(RW_BITS - 16){1'b0}}, i_wr_value} << wr_bit;

    // --------------------
    // Read-write storage
    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            rw_q <= RW_RESET;
        end
        else
        begin
            rw_q <= i_wr_en ? ((rw_q & ~wr_mask_vec) | (wr_val_vec & wr_mask_vec)) : rw_q;
            if (i_launch)
            begin
                rw_q[RWPOS_CFG_RD_EN] <= 1'b0;
                rw_q[RWPOS_CFG_WR_EN] <= 1'b0;
            end
            if (i_auto_wr)
            begin
                rw_q[RWPOS_CFG_WR_EN]               <= 1'b1;
                rw_q[RWPOS_MGMT_DI +: 32]           <= AUTO_WR_DATA;
                rw_q[RWPOS_MGMT_DWADDR +: 10]       <= AUTO_WR_DWADDR;
                rw_q[RWPOS_MGMT_WR_READONLY]        <= 1'b0;
                rw_q[RWPOS_MGMT_RW1C_AS_RW]         <= 1'b0;
                rw_q[RWPOS_MGMT_BYTE_EN +: 4]       <= {rw_q[RWPOS_STATUS_CL_EN], 1'b0,
                                                        {2{rw_q[RWPOS_COMMAND_EN]}}};
            end
        end
    end

    // --------------------
    // Field outputs
    assign o_fields.di            = rw_q[RWPOS_MGMT_DI +: 32];
    assign o_fields.dwaddr        = rw_q[RWPOS_MGMT_DWADDR +: 10];
    assign o_fields.wr_readonly   = rw_q[RWPOS_MGMT_WR_READONLY];
    assign o_fields.wr_rw1c_as_rw = rw_q[RWPOS_MGMT_RW1C_AS_RW];
    assign o_fields.byte_en       = rw_q[RWPOS_MGMT_BYTE_EN +: 4];

    assign o_rd_start      = rw_q[RWPOS_CFG_RD_EN];
    assign o_wr_start      = rw_q[RWPOS_CFG_WR_EN];
    assign o_wait_complete = rw_q[RWPOS_WAIT_COMPLETE];
    assign o_status_cl_en  = rw_q[RWPOS_STATUS_CL_EN];
    assign o_command_en    = rw_q[RWPOS_COMMAND_EN];
    assign o_cl_period     = rw_q[RWPOS_CL_PERIOD +: 32];
    assign o_pcie_id       = {i_status.func, i_status.device, i_status.bus};

endmodule

//--- cfg_mgmt_seq.sv
`timescale 1ns/10ps

module cfg_mgmt_seq import cfg_pkg::*; (
    input  logic             clk_pcie,
    input  logic             rst,
    input  logic             i_rd_start,
    input  logic             i_wr_start,
    input  cfg_mgmt_fields_t i_fields,
    input  logic             i_status_cl_en,
    input  logic             i_command_en,
    input  logic [31:0]      i_cl_period,
    input  logic             i_access,
    input  cfg_mgmt_rsp_t    i_mgmt,
    output cfg_mgmt_req_t    o_mgmt,
    output logic             o_launch,
    output logic             o_auto_wr,
    output logic             o_busy,
    output logic [1:0]       o_mgmt_en,
    output logic [31:0]      o_result,
    output logic [9:0]       o_result_addr,
    output logic [3:0]       o_result_be,
    output logic             o_result_valid
);

    logic        rd_en_q;
    logic        wr_en_q;
    logic        timer_run;
    logic [31:0] cl_cnt;

    // --------------------
    // Core request
    assign o_mgmt.rd_en         = rd_en_q & ~i_mgmt.rd_wr_done;   // Drop with done
    assign o_mgmt.wr_en         = wr_en_q & ~i_mgmt.rd_wr_done;
    assign o_mgmt.di            = i_fields.di;
    assign o_mgmt.dwaddr        = i_fields.dwaddr;
    assign o_mgmt.byte_en       = i_fields.byte_en;
    assign o_mgmt.wr_readonly   = i_fields.wr_readonly;
    assign o_mgmt.wr_rw1c_as_rw = i_fields.wr_rw1c_as_rw;
    assign o_mgmt_en            = {o_mgmt.wr_en, o_mgmt.rd_en};

    assign o_busy   = i_rd_start | i_wr_start | rd_en_q | wr_en_q;
    assign o_launch = (i_rd_start | i_wr_start) & ~rd_en_q & ~wr_en_q;

    // Status-clear timer runs only when everything is idle
    assign timer_run = (i_status_cl_en | i_command_en) & ~o_busy & ~i_access;
    assign o_auto_wr = timer_run & (cl_cnt >= i_cl_period);

    // --------------------
    // Start, enable, done handshake
    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            rd_en_q        <= 1'b0;
            wr_en_q        <= 1'b0;
            o_result_valid <= 1'b0;
            o_result       <= '0;
            o_result_addr  <= '0;
            o_result_be    <= '0;
        end
        else if (i_mgmt.rd_wr_done && (rd_en_q || wr_en_q))
        begin
            rd_en_q        <= 1'b0;
            wr_en_q        <= 1'b0;
            o_result_valid <= 1'b1;
            o_result       <= i_mgmt.data_out;
            o_result_addr  <= i_fields.dwaddr;
            o_result_be    <= i_fields.byte_en;
        end
        else if (o_launch)
        begin
            rd_en_q        <= i_rd_start;                  // Read wins over write
            wr_en_q        <= ~i_rd_start;
            o_result_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_pcie)
    begin
        if (rst)
        begin
            cl_cnt <= '0;
        end
        else if (o_auto_wr)
        begin
            cl_cnt <= '0;
        end
        else if (timer_run)
        begin
            cl_cnt <= cl_cnt + 1'b1;
        end
    end

endmodule

//--- pcie_cfg_top.sv
`timescale 1ns/10ps

module pcie_cfg_top import cfg_pkg::*; #(
    parameter int CMD_DEPTH = 16,
    parameter int RSP_DEPTH = 16
) (
    input  logic          clk_pcie,
    input  logic          rst,
    input  logic          i_cmd_valid,
    input  cfg_cmd_t      i_cmd,
    output logic          o_cmd_ready,
    output logic          o_rsp_valid,
    output cfg_rsp_t      o_rsp,
    input  logic          i_rsp_ready,
    output cfg_mgmt_req_t o_mgmt,
    input  cfg_mgmt_rsp_t i_mgmt,
    input  cfg_status_t   i_status,
    output logic [15:0]   o_pcie_id
);

    logic             cmd_full;
    logic             cmd_valid;
    cfg_cmd_t         cmd;
    logic             cmd_pop;
    logic             rsp_hold;
    logic             rsp_push;
    cfg_rsp_t         rsp;
    logic [15:0]      rd_addr;
    logic [15:0]      rd_data;
    logic             wr_en;
    logic [15:0]      wr_addr;
    logic [15:0]      wr_value;
    logic [15:0]      wr_mask;
    logic             access;
    cfg_mgmt_fields_t fields;
    logic             rd_start;
    logic             wr_start;
    logic             wait_complete;
    logic             status_cl_en;
    logic             command_en;
    logic [31:0]      cl_period;
    logic             launch;
    logic             auto_wr;
    logic             seq_busy;
    logic [1:0]       mgmt_en;
    logic [31:0]      result;
    logic [9:0]       result_addr;
    logic [3:0]       result_be;
    logic             result_valid;

    assign o_cmd_ready = ~cmd_full;

    // --------------------
    // Command and response buffering
    cfg_fifo #(.payload_t(cfg_cmd_t), .DEPTH(CMD_DEPTH)) u_cmd_fifo (
        .clk_pcie(clk_pcie), .rst(rst),
        .i_push(i_cmd_valid), .i_data(i_cmd), .o_full(cmd_full), .o_free_lt2(),
        .i_pop(cmd_pop), .o_data(cmd), .o_valid(cmd_valid)
    );

    cfg_fifo #(.payload_t(cfg_rsp_t), .DEPTH(RSP_DEPTH)) u_rsp_fifo (
        .clk_pcie(clk_pcie), .rst(rst),
        .i_push(rsp_push), .i_data(rsp), .o_full(), .o_free_lt2(rsp_hold),
        .i_pop(i_rsp_ready), .o_data(o_rsp), .o_valid(o_rsp_valid)
    );

    cfg_cmd_decoder u_decoder (
        .clk_pcie(clk_pcie), .rst(rst),
        .i_cmd_valid(cmd_valid), .i_cmd(cmd), .o_cmd_pop(cmd_pop),
        .i_rsp_hold(rsp_hold), .i_seq_busy(seq_busy), .i_wait_complete(wait_complete),
        .o_rd_addr(rd_addr), .i_rd_data(rd_data),
        .o_wr_en(wr_en), .o_wr_addr(wr_addr), .o_wr_value(wr_value), .o_wr_mask(wr_mask),
        .o_access(access), .o_rsp_push(rsp_push), .o_rsp(rsp)
    );

    // --------------------
    // Registers and core handshake
    cfg_regfile u_regfile (
        .clk_pcie(clk_pcie), .rst(rst),
        .i_rd_addr(rd_addr), .o_rd_data(rd_data),
        .i_wr_en(wr_en), .i_wr_addr(wr_addr), .i_wr_value(wr_value), .i_wr_mask(wr_mask),
        .i_launch(launch), .i_auto_wr(auto_wr), .i_mgmt_en(mgmt_en),
        .i_result(result), .i_result_addr(result_addr), .i_result_be(result_be),
        .i_result_valid(result_valid), .i_status(i_status), .o_fields(fields),
        .o_rd_start(rd_start), .o_wr_start(wr_start), .o_wait_complete(wait_complete),
        .o_status_cl_en(status_cl_en), .o_command_en(command_en),
        .o_cl_period(cl_period), .o_pcie_id(o_pcie_id)
    );

    cfg_mgmt_seq u_seq (
        .clk_pcie(clk_pcie), .rst(rst),
        .i_rd_start(rd_start), .i_wr_start(wr_start), .i_fields(fields),
        .i_status_cl_en(status_cl_en), .i_command_en(command_en),
        .i_cl_period(cl_period), .i_access(access),
        .i_mgmt(i_mgmt), .o_mgmt(o_mgmt),
        .o_launch(launch), .o_auto_wr(auto_wr), .o_busy(seq_busy), .o_mgmt_en(mgmt_en),
        .o_result(result), .o_result_addr(result_addr), .o_result_be(result_be),
        .o_result_valid(result_valid)
    );

endmodule

//--- tb_pcie_cfg.sv
`timescale 1ns/10ps

module tb_pcie_cfg import cfg_pkg::*; ();

    localparam int NUM_CMDS = 160;         // Fixed reads, writes, back-pressure and polls

    typedef struct packed {
        logic [15:0] addr;
        logic [15:0] data;
        logic        check;                // Zero for reads whose value is fetched later
    } exp_rsp_t;

    logic          clk_pcie;
    logic          rst;
    logic          i_cmd_valid;
    cfg_cmd_t      i_cmd;
    logic          o_cmd_ready;
    logic          o_rsp_valid;
    cfg_rsp_t      o_rsp;
    logic          i_rsp_ready;
    cfg_mgmt_req_t o_mgmt;
    cfg_mgmt_rsp_t i_mgmt;
    cfg_status_t   i_status;
    logic [15:0]   o_pcie_id;

    integer        seed;
    logic [31:0]   cfg_space [1024];       // Core configuration space
    logic [159:0]  rw_model;               // Read-write half
    exp_rsp_t      exp_q[$];
    cfg_mgmt_req_t wr_log[$];              // Writes seen by the core
    logic [15:0]   last_data;

    pcie_cfg_top #(
        .CMD_DEPTH(16),
        .RSP_DEPTH(16)
    ) u_pcie_cfg_top (
        .clk_pcie(clk_pcie), .rst(rst),
        .i_cmd_valid(i_cmd_valid), .i_cmd(i_cmd), .o_cmd_ready(o_cmd_ready),
        .o_rsp_valid(o_rsp_valid), .o_rsp(o_rsp), .i_rsp_ready(i_rsp_ready),
        .o_mgmt(o_mgmt), .i_mgmt(i_mgmt), .i_status(i_status), .o_pcie_id(o_pcie_id)
    );

    initial
    begin
        clk_pcie = 1'b0;
        forever #5 clk_pcie = ~clk_pcie;
    end

    // --------------------
    // Helpers
    function automatic logic [15:0] swap16(input logic [15:0] v);
        return {v[7:0], v[15:8]};
    endfunction

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] di,
                                                input logic [3:0] be);
        logic [31:0] v;
        v = old;
        for (int b = 0; b < 4; b++)
        begin
            if (be[b])
            begin
                v[b*8 +: 8] = di[b*8 +: 8];
            end
        end
        return v;
    endfunction

    // Read-only half before any configuration access
    function automatic logic [15:0] ro_expect(input int off);
        logic [191:0] v;
        v           = '0;
        v[15:0]     = 16'h2301;
        v[63:32]    = 32'd24;
        v[79:64]    = {i_status.func, i_status.device, i_status.bus};
        v[95:80]    = i_status.command;
        v[111:96]   = i_status.status;
        return v[off*8 +: 16];
    endfunction

    task automatic fail_and_stop();
        $display("Test failed");
        $fatal(1, "Simulation stopped after a failure");
    endtask

    task automatic stop_on_error(input string msg);
        $display("ERR %0t: %s", $time, msg);
        fail_and_stop();
    endtask

    task automatic send_cmd(input logic [15:0] addr, input logic [15:0] value,
                            input logic [15:0] mask, input logic [3:0] typ);
        logic accepted;
        i_cmd.value = swap16(value);       // Host sends swapped bytes
        i_cmd.mask  = swap16(mask);
        i_cmd.addr  = addr;
        i_cmd.typ   = typ;
        i_cmd.rsvd  = '0;
        i_cmd_valid = 1'b1;
        accepted    = 1'b0;
        while (!accepted)
        begin
            @(negedge clk_pcie);
            accepted = o_cmd_ready;        // Stable until the next edge
            @(posedge clk_pcie);
        end
        #1;
        i_cmd_valid = 1'b0;
    endtask

    task automatic queue_read(input logic [15:0] addr, input logic [15:0] data,
                              input logic check);
        exp_rsp_t e;
        e.addr  = addr;
        e.data  = data;
        e.check = check;
        exp_q.push_back(e);
        send_cmd(addr, 16'h0000, 16'h0000, 4'b0001);
    endtask

    task automatic write_reg(input logic [15:0] addr, input logic [15:0] value,
                             input logic [15:0] mask);
        logic [159:0] m;
        logic [159:0] v;
        if (addr[15])
        begin
            m        = 160'(mask) << (int'(addr[14:0]) * 8);
            v        = 160'(value) << (int'(addr[14:0]) * 8);
            rw_model = (rw_model & ~m) | (v & m);
        end
        send_cmd(addr, value, mask, 4'b0010);
    endtask

    task automatic drain();
        while (exp_q.size() != 0)
        begin
            @(posedge clk_pcie);
        end
        #1;
    endtask

    task automatic read_reg(input logic [15:0] addr, output logic [15:0] data);
        queue_read(addr, 16'h0000, 1'b0);
        drain();
        data = last_data;
    endtask

    // Poll the latched-result word until valid
    task automatic wait_result(output logic [15:0] fld);
        logic done;
        done = 1'b0;
        for (int i = 0; i < 100 && !done; i++)
        begin
            read_reg(16'h0010, fld);
            done = fld[11];
        end
        if (!done)
        begin
            $display("The configuration access never completed");
            fail_and_stop();
        end
    endtask

    task automatic wait_log(input int n0);
        int waited;
        waited = 0;
        while (wr_log.size() <= n0 && waited < 1000)
        begin
            @(posedge clk_pcie);
            waited++;
        end
        #1;
        if (wr_log.size() <= n0)
        begin
            $display("The status-clear timer never wrote to the core");
            fail_and_stop();
        end
    endtask

    // --------------------
    // Core model and response monitor
    initial
    begin
        cfg_mgmt_req_t req;
        logic [31:0]   r;
        i_mgmt = '0;
        forever
        begin
            @(negedge clk_pcie);
            if (!rst && (o_mgmt.rd_en || o_mgmt.wr_en))
            begin
                req = o_mgmt;
                if (req.wr_en)
                begin
                    wr_log.push_back(req);
                end
                r = $random(seed);
                repeat (1 + int'(r[2:0])) @(posedge clk_pcie);   // 1 to 8 cycles
                #1;
                if (req.wr_en)
                begin
                    cfg_space[req.dwaddr] = merge_bytes(cfg_space[req.dwaddr], req.di,
                                                        req.byte_en);
                end
                i_mgmt.data_out   = cfg_space[req.dwaddr];
                i_mgmt.rd_wr_done = 1'b1;
                @(posedge clk_pcie);
                #1;
                i_mgmt.rd_wr_done = 1'b0;
            end
        end
    end

    always @(negedge clk_pcie)
    begin
        exp_rsp_t e;
        if (!rst && o_rsp_valid && i_rsp_ready)
        begin
            assert (exp_q.size() != 0)
            else
            begin
                $display("A response arrived with no read outstanding");
                fail_and_stop();
            end
            e         = exp_q.pop_front();
            last_data = swap16(o_rsp.data);
            assert (o_rsp.addr == e.addr)
            else stop_on_error($sformatf("response address %h, expected %h", o_rsp.addr, e.addr));
            assert (!e.check || last_data == e.data)
            else stop_on_error($sformatf("read of %h gave %h, expected %h",
                                         e.addr, last_data, e.data));
        end
    end

    initial
    begin
        repeat (NUM_CMDS * 200) @(posedge clk_pcie);
        $display("Timeout after %0d cycles, the run did not finish", NUM_CMDS * 200);
        fail_and_stop();
    end

    // --------------------
    // Tests
    task automatic read_fixed_words();
        queue_read(16'h8000, 16'h6745, 1'b1);
        queue_read(16'h8004, 16'd20, 1'b1);
        queue_read(16'h0000, 16'h2301, 1'b1);
        queue_read(16'h0004, 16'd24, 1'b1);
        queue_read(16'h8014, 16'h0000, 1'b1);   // Just past each half
        queue_read(16'h0018, 16'h0000, 1'b1);
        drain();
        assert (o_pcie_id == {i_status.func, i_status.device, i_status.bus})
        else stop_on_error($sformatf("PCIe ID %h does not match the status input", o_pcie_id));
    endtask

    task automatic random_masked_writes();
        logic [31:0] r;
        logic [31:0] r2;
        logic [15:0] off;
        for (int i = 0; i < 30; i++)
        begin
            r   = $random(seed);
            r2  = $random(seed);
            off = 16'd4 + 16'(r[3:0]);          // Control bytes stay untouched
            if (r[7:5] == 3'd0)
            begin
                off = 16'd0;
            end
            write_reg(16'h8000 | off, r2[15:0], r2[31:16]);
        end
        for (int i = 0; i < 10; i++)
        begin
            r  = $random(seed);
            r2 = $random(seed);
            write_reg(16'(r[4:0]), r2[15:0], r2[31:16]);
        end
        for (int off2 = 0; off2 < 20; off2 += 2)
        begin
            queue_read(16'h8000 | 16'(off2), rw_model[off2*8 +: 16], 1'b1);
        end
        for (int off2 = 0; off2 < 24; off2 += 2)
        begin
            queue_read(16'(off2), ro_expect(off2), 1'b1);
        end
        drain();
    endtask

    task automatic backpressure_reads();
        logic [31:0] r;
        logic [15:0] off;
        logic        saw_full;
        int          waited;
        saw_full    = 1'b0;
        waited      = 0;
        i_rsp_ready = 1'b0;
        fork
            begin
                for (int i = 0; i < 40; i++)
                begin
                    r   = $random(seed);
                    off = (16'(r[3:0]) % 16'd10) << 1;
                    queue_read(16'h8000 | off, rw_model[int'(off)*8 +: 16], 1'b1);
                end
            end
            begin
                while (!saw_full && waited < 500)
                begin
                    @(negedge clk_pcie);
                    saw_full = ~o_cmd_ready;
                    waited++;
                end
                repeat (10) @(posedge clk_pcie);
                #1;
                i_rsp_ready = 1'b1;
            end
        join
        if (!saw_full)
        begin
            $display("Command ready never fell while responses were held back");
            fail_and_stop();
        end
        drain();
    endtask

    task automatic cfg_read_end_to_end();
        logic [31:0] r;
        logic [9:0]  dw;
        logic [15:0] fld;
        logic [15:0] lo;
        logic [15:0] hi;
        r  = $random(seed);
        dw = r[9:0];
        write_reg(16'h800C, {6'b000000, dw}, 16'hffff);   // Byte enables and flags zero
        write_reg(16'h8002, 16'h0005, 16'h0005);          // Read start and wait_complete
        wait_result(fld);
        read_reg(16'h0014, lo);
        read_reg(16'h0016, hi);
        assert (fld[9:0] == dw && fld[15:12] == 4'h0)
        else stop_on_error($sformatf("latched address field %h, dword %h", fld, dw));
        assert ({hi, lo} == cfg_space[dw])
        else stop_on_error($sformatf("config read of %h gave %h, expected %h",
                                     dw, {hi, lo}, cfg_space[dw]));
    endtask

    task automatic cfg_write_end_to_end();
        logic [31:0] r;
        logic [31:0] di;
        logic [31:0] merged;
        logic [9:0]  dw;
        logic [3:0]  be;
        logic [15:0] fld;
        logic [15:0] lo;
        logic [15:0] hi;
        int          n0;
        r      = $random(seed);
        di     = $random(seed);
        dw     = r[9:0];
        be     = (r[13:10] == 4'h0) ? 4'h6 : r[13:10];
        merged = merge_bytes(cfg_space[dw], di, be);
        n0     = wr_log.size();
        write_reg(16'h8008, di[15:0], 16'hffff);
        write_reg(16'h800A, di[31:16], 16'hffff);
        write_reg(16'h800C, {be, 2'b00, dw}, 16'hffff);
        write_reg(16'h8002, 16'h0006, 16'h0006);          // Write start
        wait_result(fld);
        assert (wr_log.size() == n0 + 1 && wr_log[n0].dwaddr == dw
                && wr_log[n0].di == di && wr_log[n0].byte_en == be)
        else stop_on_error($sformatf("core write to %h with data %h and enables %b missing",
                                     dw, di, be));
        write_reg(16'h800C, {6'b000000, dw}, 16'hffff);
        write_reg(16'h8002, 16'h0005, 16'h0005);
        wait_result(fld);
        read_reg(16'h0014, lo);
        read_reg(16'h0016, hi);
        assert ({hi, lo} == merged)
        else stop_on_error($sformatf("dword %h reads %h after write, expected %h",
                                     dw, {hi, lo}, merged));
    endtask

    task automatic status_clear_timer();
        logic [15:0] data;
        int          n0;
        n0 = wr_log.size();
        write_reg(16'h8010, 16'd20, 16'hffff);
        write_reg(16'h8012, 16'h0000, 16'hffff);
        write_reg(16'h800C, 16'hcfff, 16'hffff);          // Fields the auto-write replaces
        write_reg(16'h8002, 16'h0010, 16'h0010);          // command_en
        wait_log(n0);
        assert (wr_log[n0].dwaddr == 10'd1 && wr_log[n0].di == 32'hff000406
                && wr_log[n0].byte_en == 4'b0011 && !wr_log[n0].wr_readonly
                && !wr_log[n0].wr_rw1c_as_rw)
        else stop_on_error($sformatf("timer write %h, expected dword 1, ff000406, 0011",
                                     wr_log[n0]));
        write_reg(16'h8002, 16'h0008, 16'h0008);          // status_cl_en as well
        read_reg(16'h8002, data);                          // Older timer writes are logged by now
        n0 = wr_log.size();
        wait_log(n0);
        assert (wr_log[n0].dwaddr == 10'd1 && wr_log[n0].di == 32'hff000406
                && wr_log[n0].byte_en == 4'b1011)
        else stop_on_error($sformatf("timer write %h, expected dword 1, ff000406, 1011",
                                     wr_log[n0]));
    endtask

    // --------------------
    // Main sequence
    initial
    begin
        logic [31:0] r;
        logic [31:0] r2;
        seed        = 32'h75c4_e96e;
        rst         = 1'b1;
        i_cmd_valid = 1'b0;
        i_cmd       = '0;
        i_rsp_ready = 1'b1;
        r           = $random(seed);
        r2          = $random(seed);
        i_status    = {r[15:0], r2};
        for (int i = 0; i < 1024; i++)
        begin
            cfg_space[i] = $random(seed);
        end
        rw_model           = '0;
        rw_model[15:0]     = 16'h6745;
        rw_model[63:32]    = 32'd20;
        rw_model[111:108]  = 4'hf;                 // Byte enables reset to ones
        rw_model[159:128]  = 32'd62500;
        repeat (5) @(posedge clk_pcie);
        #1;
        rst = 1'b0;
        assert (o_cmd_ready && !o_rsp_valid && !o_mgmt.rd_en && !o_mgmt.wr_en)
        else stop_on_error("outputs not idle after reset");

        read_fixed_words();
        random_masked_writes();
        backpressure_reads();
        cfg_read_end_to_end();
        cfg_write_end_to_end();
        status_clear_timer();

        $display("Test completed successfully");
        $finish;
    end

endmodule

//--- filelist.f
cfg_pkg.sv
cfg_fifo.sv
cfg_cmd_decoder.sv
cfg_regfile.sv
cfg_mgmt_seq.sv
pcie_cfg_top.sv
tb_pcie_cfg.sv

//--- Makefile
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/10ps
TOP       = tb_pcie_cfg
FILELIST  = filelist.f
BUILD_DIR = obj_dir
LOG       = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
